//--- sources.f
hdl/isa_pkg.sv
hdl/core_cfg_pkg.sv
hdl/instr_fetch.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/mini_core.sv
bench/core_asserts.sv
bench/core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator, pass only on the pass line
verilator --binary --timing --assert -f sources.f --top-module core_tb \
    -Mdir obj_dir -o core_sim || exit 1
./obj_dir/core_sim > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- bench/core_tb.sv
// testbench for the mini core
// memory model with random grant and response stalls, a program table
// with a golden register model, and in-order checks of every report
module core_tb
    import isa_pkg::*;
    import core_cfg_pkg::*;
();

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int SHAMT_W        = $clog2(DATA_WIDTH);
    localparam int PROG_LEN       = 23;
    localparam int REPORT_TIMEOUT = 60;
    localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR = 32'h0000_1000;

    // what an entry is expected to retire as
    localparam int KIND_NONE    = 0;
    localparam int KIND_REPORT  = 1;
    localparam int KIND_ILLEGAL = 2;

    logic                  clk_i;
    logic                  reset_i;
    logic                  fetch_enable_i;
    logic [ADDR_WIDTH-1:0] boot_addr_i;
    logic                  instr_req_o;
    logic [ADDR_WIDTH-1:0] instr_addr_o;
    logic                  instr_gnt_i;
    logic                  instr_rvalid_i;
    logic [INSTR_W-1:0]    instr_rdata_i;
    logic                  wb_valid_o;
    logic [REG_IDX_W-1:0]  wb_rd_o;
    logic [DATA_WIDTH-1:0] wb_data_o;
    logic                  illegal_o;

    // program table and expected reports
    string                 test_name [PROG_LEN];
    logic [INSTR_W-1:0]    prog_mem  [PROG_LEN];
    int                    exp_kind  [PROG_LEN];
    logic [REG_IDX_W-1:0]  exp_rd    [PROG_LEN];
    logic [DATA_WIDTH-1:0] exp_data  [PROG_LEN];
    int                    prog_count;

    int          checks;
    int          value_errors;
    int          other_errors;
    int          addr_errors;
    int          assert_errors;
    logic        timed_out;
    logic [31:0] rng_state = 32'hfaa4;

    mini_core #(
        .DATA_WIDTH      ( DATA_WIDTH ),
        .ADDR_WIDTH      ( ADDR_WIDTH ),
        .MAX_OUTSTANDING ( 2          )
    ) dut0 (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .wb_valid_o     ( wb_valid_o     ),
        .wb_rd_o        ( wb_rd_o        ),
        .wb_data_o      ( wb_data_o      ),
        .illegal_o      ( illegal_o      )
    );

    bind mini_core core_asserts #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    ) asserts0 (
        .clk_i        ( clk_i        ),
        .reset_i      ( reset_i      ),
        .instr_req_o  ( instr_req_o  ),
        .instr_gnt_i  ( instr_gnt_i  ),
        .instr_addr_o ( instr_addr_o ),
        .wb_valid_o   ( wb_valid_o   ),
        .wb_rd_o      ( wb_rd_o      ),
        .illegal_o    ( illegal_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // stall of 0 to 3 cycles
    function automatic int next_delay();
        rng_state = xorshift(rng_state);
        return int'(rng_state[1:0]);
    endfunction

    function automatic logic [INSTR_W-1:0] encode(
        input logic [3:0]  op,
        input logic [3:0]  rd,
        input logic [3:0]  rs1,
        input logic [3:0]  rs2,
        input logic [15:0] imm
    );
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic add_instr(input string name, input logic [INSTR_W-1:0] word);
        test_name[prog_count] = name;
        prog_mem[prog_count]  = word;
        prog_count++;
    endtask

    task automatic load_program();
        add_instr("lui_r1",      encode(OP_LUI,  4'd1,  4'd0,  4'd0,  16'h1234));
        add_instr("addi_fwd",    encode(OP_ADDI, 4'd1,  4'd1,  4'd0,  16'h5678));
        add_instr("addi_neg",    encode(OP_ADDI, 4'd2,  4'd0,  4'd0,  16'hfffd));
        add_instr("add",         encode(OP_ADD,  4'd3,  4'd1,  4'd2,  16'h0000));
        add_instr("sub",         encode(OP_SUB,  4'd4,  4'd1,  4'd2,  16'h0000));
        add_instr("and",         encode(OP_AND,  4'd5,  4'd1,  4'd2,  16'h0000));
        add_instr("or_fwd",      encode(OP_OR,   4'd6,  4'd3,  4'd4,  16'h0000));
        add_instr("xor_fwd",     encode(OP_XOR,  4'd7,  4'd5,  4'd6,  16'h0000));
        add_instr("addi_shamt",  encode(OP_ADDI, 4'd8,  4'd0,  4'd0,  16'd36));
        add_instr("sll_wrap",    encode(OP_SLL,  4'd9,  4'd1,  4'd8,  16'h0000));
        add_instr("inc_1",       encode(OP_ADDI, 4'd10, 4'd10, 4'd0,  16'h0001));
        add_instr("inc_2",       encode(OP_ADDI, 4'd10, 4'd10, 4'd0,  16'h0001));
        add_instr("double",      encode(OP_ADD,  4'd10, 4'd10, 4'd10, 16'h0000));
        add_instr("write_r0",    encode(OP_ADDI, 4'd0,  4'd1,  4'd0,  16'h0005));
        add_instr("read_r0",     encode(OP_ADD,  4'd11, 4'd0,  4'd1,  16'h0000));
        add_instr("illegal_9",   encode(4'h9,    4'd3,  4'd1,  4'd1,  16'hbeef));
        add_instr("after_ill_9", encode(OP_ADD,  4'd12, 4'd3,  4'd0,  16'h0000));
        add_instr("illegal_f",   encode(4'hf,    4'd12, 4'd0,  4'd0,  16'h0000));
        add_instr("after_ill_f", encode(OP_OR,   4'd13, 4'd12, 4'd12, 16'h0000));
        add_instr("xor_self",    encode(OP_XOR,  4'd14, 4'd14, 4'd1,  16'h0000));
        add_instr("sll_29",      encode(OP_SLL,  4'd15, 4'd2,  4'd2,  16'h0000));
        add_instr("lui_top",     encode(OP_LUI,  4'd1,  4'd0,  4'd0,  16'hffff));
        add_instr("sub_from_r0", encode(OP_SUB,  4'd2,  4'd0,  4'd1,  16'h0000));
    endtask

    // golden model applying the operation rules in table order
    task automatic predict_results();
        logic [DATA_WIDTH-1:0] gold [NUM_REGS];
        logic [3:0]            op;
        logic [REG_IDX_W-1:0]  rd;
        logic [IMM_W-1:0]      imm;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] sext;
        logic [DATA_WIDTH-1:0] res;
        logic                  legal;
        for (int r = 0; r < NUM_REGS; r++) begin
            gold[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            op    = prog_mem[i][31:28];
            rd    = prog_mem[i][RD_LSB +: REG_IDX_W];
            imm   = prog_mem[i][IMM_W-1:0];
            a     = gold[prog_mem[i][RS1_LSB +: REG_IDX_W]];
            b     = gold[prog_mem[i][RS2_LSB +: REG_IDX_W]];
            sext  = {{(DATA_WIDTH-IMM_W){imm[IMM_W-1]}}, imm};
            res   = '0;
            legal = 1'b1;
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_SLL:  res = a << b[SHAMT_W-1:0];
                OP_ADDI: res = a + sext;
                OP_LUI:  res[31:16] = imm;
                default: legal = 1'b0;
            endcase
            exp_rd[i]   = rd;
            exp_data[i] = res;
            if (!legal) begin
                exp_kind[i] = KIND_ILLEGAL;
            end else if (rd == '0) begin
                exp_kind[i] = KIND_NONE;
            end else begin
                exp_kind[i] = KIND_REPORT;
                gold[rd]    = res;
            end
        end
    endtask

    function automatic logic [INSTR_W-1:0] read_word(input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] idx;
        idx = (addr - BOOT_ADDR) >> 2;
        if (idx < ADDR_WIDTH'(PROG_LEN)) begin
            return prog_mem[int'(idx)];
        end
        // beyond the program an addi to r0 with the address folded into imm
        return {OP_ADDI, 4'h0, 4'h0, 4'h0, addr[31:16] ^ addr[15:0]};
    endfunction

    // memory model driving its inputs 1 unit after the rising edge
    initial begin : mem_model
        logic                  req_seen;
        logic [ADDR_WIDTH-1:0] addr_seen;
        logic [ADDR_WIDTH-1:0] next_addr;
        logic [ADDR_WIDTH-1:0] resp_addr_q [$];
        int                    resp_wait_q [$];
        int                    gnt_wait;
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        req_seen       = 1'b0;
        addr_seen      = '0;
        next_addr      = BOOT_ADDR;
        addr_errors    = 0;
        gnt_wait       = next_delay();
        forever begin
            @(posedge clk_i);
            #1;
            // handshake of the edge just passed
            if (req_seen && instr_gnt_i) begin
                if (addr_seen != next_addr) begin
                    $display("error fetch_addr: expected %h, actual %h", next_addr, addr_seen);
                    addr_errors++;
                end
                next_addr = addr_seen + 32'd4;
                resp_addr_q.push_back(addr_seen);
                resp_wait_q.push_back(next_delay());
            end
            instr_rvalid_i = 1'b0;
            if (resp_addr_q.size() > 0) begin
                if (resp_wait_q[0] == 0) begin
                    instr_rvalid_i = 1'b1;
                    instr_rdata_i  = read_word(resp_addr_q.pop_front());
                    void'(resp_wait_q.pop_front());
                end else begin
                    resp_wait_q[0] = resp_wait_q[0] - 1;
                end
            end
            instr_gnt_i = 1'b0;
            if (instr_req_o) begin
                if (gnt_wait == 0) begin
                    instr_gnt_i = 1'b1;
                    gnt_wait    = next_delay();
                end else begin
                    gnt_wait--;
                end
            end
            req_seen  = instr_req_o;
            addr_seen = instr_addr_o;
        end
    end

    task automatic wait_for_report(output logic got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < REPORT_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
            got = wb_valid_o || illegal_o;
        end
    endtask

    task automatic check_report(input int i);
        checks++;
        if (exp_kind[i] == KIND_ILLEGAL) begin
            if (!illegal_o || wb_valid_o) begin
                $display("error %s: expected illegal_o 1 wb_valid_o 0, actual %b %b",
                         test_name[i], illegal_o, wb_valid_o);
                value_errors++;
            end
        end else if (!wb_valid_o) begin
            $display("error %s: expected wb_valid_o 1, actual 0 with illegal_o %b",
                     test_name[i], illegal_o);
            value_errors++;
        end else begin
            if (wb_rd_o != exp_rd[i]) begin
                $display("error %s: expected rd %0d, actual %0d",
                         test_name[i], exp_rd[i], wb_rd_o);
                value_errors++;
            end
            if (wb_data_o != exp_data[i]) begin
                $display("error %s: expected data %h, actual %h",
                         test_name[i], exp_data[i], wb_data_o);
                value_errors++;
            end
        end
    endtask

    initial begin : main_seq
        logic got;
        reset_i        = 1'b1;
        fetch_enable_i = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        checks         = 0;
        value_errors   = 0;
        other_errors   = 0;
        assert_errors  = 0;
        timed_out      = 1'b0;
        prog_count     = 0;
        load_program();
        predict_results();
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // core must stay quiet until fetch is enabled
        repeat (4) begin
            @(posedge clk_i);
            #1;
            if (instr_req_o || wb_valid_o || illegal_o) begin
                $display("request or report seen before fetch was enabled");
                other_errors++;
            end
        end
        fetch_enable_i = 1'b1;
        for (int i = 0; i < PROG_LEN && !timed_out; i++) begin
            if (exp_kind[i] != KIND_NONE) begin
                wait_for_report(got);
                if (!got) begin
                    $display("timed out waiting for the report of %s", test_name[i]);
                    timed_out = 1'b1;
                end else begin
                    check_report(i);
                end
            end
        end
        // only r0 fill words follow so nothing else may retire
        if (!timed_out) begin
            repeat (20) begin
                @(posedge clk_i);
                #1;
                if (wb_valid_o || illegal_o) begin
                    $display("unexpected report after the last table entry");
                    other_errors++;
                end
            end
        end
        assert_errors = dut0.asserts0.fail_count;
        $display("checks %0d, errors: value %0d, address %0d, other %0d, assertion %0d",
                 checks, value_errors, addr_errors, other_errors, assert_errors);
        if (value_errors == 0 && addr_errors == 0 && other_errors == 0
                && assert_errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- bench/core_asserts.sv
// protocol checks bound into the mini core
// memory request hold and report port sanity
module core_asserts import isa_pkg::*; #(
    parameter int ADDR_WIDTH = 32
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  instr_req_o,
    input logic                  instr_gnt_i,
    input logic [ADDR_WIDTH-1:0] instr_addr_o,
    input logic                  wb_valid_o,
    input logic [REG_IDX_W-1:0]  wb_rd_o,
    input logic                  illegal_o
);

    // number of failed assertions
    int fail_count = 0;

    // an ungranted request stays up with the same address
    addr_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
        else begin
            $error("request dropped or address changed before its grant");
            fail_count++;
        end

    report_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(wb_valid_o && illegal_o))
        else begin
            $error("wb_valid_o and illegal_o high in the same cycle");
            fail_count++;
        end

    // r0 writes retire silently
    no_r0_report_a: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o |-> (wb_rd_o != '0))
        else begin
            $error("report issued for a write to r0");
            fail_count++;
        end

endmodule

//--- hdl/mini_core.sv
// mini core top level
// fetch, decode, execute and result stages in a stall-free pipeline
module mini_core import isa_pkg::*; import core_cfg_pkg::*; #(
    parameter int DATA_WIDTH      = 32,
    parameter int ADDR_WIDTH      = 32,
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  fetch_enable_i,
    input  logic [ADDR_WIDTH-1:0] boot_addr_i,

    output logic                  instr_req_o,
    output logic [ADDR_WIDTH-1:0] instr_addr_o,
    input  logic                  instr_gnt_i,
    input  logic                  instr_rvalid_i,
    input  logic [INSTR_W-1:0]    instr_rdata_i,

    output logic                  wb_valid_o,
    output logic [REG_IDX_W-1:0]  wb_rd_o,
    output logic [DATA_WIDTH-1:0] wb_data_o,
    output logic                  illegal_o
);

    logic                  fetch_valid;
    logic [INSTR_W-1:0]    fetch_instr;

    logic [REG_IDX_W-1:0]  rf_raddr_a;
    logic [REG_IDX_W-1:0]  rf_raddr_b;
    logic [DATA_WIDTH-1:0] rf_rdata_a;
    logic [DATA_WIDTH-1:0] rf_rdata_b;

    logic                  dec_valid;
    alu_op_e               dec_op;
    logic [REG_IDX_W-1:0]  dec_rd;
    logic [DATA_WIDTH-1:0] dec_a;
    logic [DATA_WIDTH-1:0] dec_b;
    logic                  dec_illegal;

    logic                  ex_valid;
    logic [REG_IDX_W-1:0]  ex_rd;
    logic [DATA_WIDTH-1:0] ex_result;
    logic                  ex_illegal;

    // write port, also a forwarding source
    logic                  wb_we;
    logic [REG_IDX_W-1:0]  wb_waddr;
    logic [DATA_WIDTH-1:0] wb_wdata;

    instr_fetch #(
        .ADDR_WIDTH      ( ADDR_WIDTH      ),
        .MAX_OUTSTANDING ( MAX_OUTSTANDING )
    ) fetch0 (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .fetch_valid_o  ( fetch_valid    ),
        .fetch_instr_o  ( fetch_instr    )
    );

    instr_decode #(
        .DATA_WIDTH ( DATA_WIDTH )
    ) decode0 (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .fetch_valid_i ( fetch_valid ),
        .fetch_instr_i ( fetch_instr ),
        .rf_raddr_a_o  ( rf_raddr_a  ),
        .rf_raddr_b_o  ( rf_raddr_b  ),
        .rf_rdata_a_i  ( rf_rdata_a  ),
        .rf_rdata_b_i  ( rf_rdata_b  ),
        .ex_valid_i    ( ex_valid    ),
        .ex_rd_i       ( ex_rd       ),
        .ex_result_i   ( ex_result   ),
        .wb_we_i       ( wb_we       ),
        .wb_waddr_i    ( wb_waddr    ),
        .wb_wdata_i    ( wb_wdata    ),
        .dec_valid_o   ( dec_valid   ),
        .dec_op_o      ( dec_op      ),
        .dec_rd_o      ( dec_rd      ),
        .dec_a_o       ( dec_a       ),
        .dec_b_o       ( dec_b       ),
        .dec_illegal_o ( dec_illegal )
    );

    alu_execute #(
        .DATA_WIDTH ( DATA_WIDTH )
    ) execute0 (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .dec_valid_i   ( dec_valid   ),
        .dec_op_i      ( dec_op      ),
        .dec_rd_i      ( dec_rd      ),
        .dec_a_i       ( dec_a       ),
        .dec_b_i       ( dec_b       ),
        .dec_illegal_i ( dec_illegal ),
        .ex_valid_o    ( ex_valid    ),
        .ex_rd_o       ( ex_rd       ),
        .ex_result_o   ( ex_result   ),
        .ex_illegal_o  ( ex_illegal  )
    );

    result_writeback #(
        .DATA_WIDTH ( DATA_WIDTH )
    ) result0 (
        .clk_i        ( clk_i      ),
        .reset_i      ( reset_i    ),
        .ex_valid_i   ( ex_valid   ),
        .ex_rd_i      ( ex_rd      ),
        .ex_result_i  ( ex_result  ),
        .ex_illegal_i ( ex_illegal ),
        .rf_raddr_a_i ( rf_raddr_a ),
        .rf_raddr_b_i ( rf_raddr_b ),
        .rf_rdata_a_o ( rf_rdata_a ),
        .rf_rdata_b_o ( rf_rdata_b ),
        .wb_we_o      ( wb_we      ),
        .wb_waddr_o   ( wb_waddr   ),
        .wb_wdata_o   ( wb_wdata   ),
        .wb_valid_o   ( wb_valid_o ),
        .wb_rd_o      ( wb_rd_o    ),
        .wb_data_o    ( wb_data_o  ),
        .illegal_o    ( illegal_o  )
    );

endmodule

//--- hdl/result_writeback.sv
// result stage
// registers the retire report, which doubles as the register file
// write port one cycle later; owns the register file itself
module result_writeback import isa_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  ex_valid_i,
    input  logic [REG_IDX_W-1:0]  ex_rd_i,
    input  logic [DATA_WIDTH-1:0] ex_result_i,
    input  logic                  ex_illegal_i,

    input  logic [REG_IDX_W-1:0]  rf_raddr_a_i,
    input  logic [REG_IDX_W-1:0]  rf_raddr_b_i,
    output logic [DATA_WIDTH-1:0] rf_rdata_a_o,
    output logic [DATA_WIDTH-1:0] rf_rdata_b_o,

    output logic                  wb_we_o,
    output logic [REG_IDX_W-1:0]  wb_waddr_o,
    output logic [DATA_WIDTH-1:0] wb_wdata_o,

    output logic                  wb_valid_o,
    output logic [REG_IDX_W-1:0]  wb_rd_o,
    output logic [DATA_WIDTH-1:0] wb_data_o,
    output logic                  illegal_o
);

    logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];
    logic                  wb_valid_q;
    logic                  illegal_q;
    logic [REG_IDX_W-1:0]  wb_rd_q;
    logic [DATA_WIDTH-1:0] wb_data_q;

    // writes to r0 retire silently
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            wb_valid_q <= ex_valid_i && (ex_rd_i != '0);
            illegal_q  <= ex_illegal_i;
        end
        if (ex_valid_i || ex_illegal_i) begin
            wb_rd_q <= ex_rd_i;
        end
        if (ex_valid_i) begin
            wb_data_q <= ex_result_i;
        end
    end

    // register file, cleared so every register reads zero after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_valid_q) begin
            regs_q[wb_rd_q] <= wb_data_q;
        end
    end

    assign rf_rdata_a_o = regs_q[rf_raddr_a_i];
    assign rf_rdata_b_o = regs_q[rf_raddr_b_i];

    assign wb_we_o    = wb_valid_q;
    assign wb_waddr_o = wb_rd_q;
    assign wb_wdata_o = wb_data_q;

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_data_q;
    assign illegal_o  = illegal_q;

endmodule

//--- hdl/alu_execute.sv
// execute stage
// computes one ALU operation per cycle and registers the result
// together with the destination register and the illegal flag
module alu_execute import isa_pkg::*; import core_cfg_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  dec_valid_i,
    input  alu_op_e               dec_op_i,
    input  logic [REG_IDX_W-1:0]  dec_rd_i,
    input  logic [DATA_WIDTH-1:0] dec_a_i,
    input  logic [DATA_WIDTH-1:0] dec_b_i,
    input  logic                  dec_illegal_i,

    output logic                  ex_valid_o,
    output logic [REG_IDX_W-1:0]  ex_rd_o,
    output logic [DATA_WIDTH-1:0] ex_result_o,
    output logic                  ex_illegal_o
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] alu_result;
    logic                  ex_valid_q;
    logic                  ex_illegal_q;
    logic [REG_IDX_W-1:0]  ex_rd_q;
    logic [DATA_WIDTH-1:0] ex_result_q;

    always_comb begin
        case (dec_op_i)
            ALU_ADD:    alu_result = dec_a_i + dec_b_i;
            ALU_SUB:    alu_result = dec_a_i - dec_b_i;
            ALU_AND:    alu_result = dec_a_i & dec_b_i;
            ALU_OR:     alu_result = dec_a_i | dec_b_i;
            ALU_XOR:    alu_result = dec_a_i ^ dec_b_i;
            // only the low log2(width) bits of b count
            ALU_SLL:    alu_result = dec_a_i << dec_b_i[SHAMT_W-1:0];
            ALU_PASS_B: alu_result = dec_b_i;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_valid_q   <= 1'b0;
            ex_illegal_q <= 1'b0;
        end else begin
            ex_valid_q   <= dec_valid_i;
            ex_illegal_q <= dec_illegal_i;
        end
        if (dec_valid_i || dec_illegal_i) begin
            ex_rd_q <= dec_rd_i;
        end
        if (dec_valid_i) begin
            ex_result_q <= alu_result;
        end
    end

    assign ex_valid_o   = ex_valid_q;
    assign ex_illegal_o = ex_illegal_q;
    assign ex_rd_o      = ex_rd_q;
    assign ex_result_o  = ex_result_q;

endmodule

//--- hdl/instr_decode.sv
// decode stage
// registers the fetched word, splits it, reads operands with forwarding
// from execute and writeback, and flags unknown opcodes
module instr_decode import isa_pkg::*; import core_cfg_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  fetch_valid_i,
    input  logic [INSTR_W-1:0]    fetch_instr_i,

    output logic [REG_IDX_W-1:0]  rf_raddr_a_o,
    output logic [REG_IDX_W-1:0]  rf_raddr_b_o,
    input  logic [DATA_WIDTH-1:0] rf_rdata_a_i,
    input  logic [DATA_WIDTH-1:0] rf_rdata_b_i,

    input  logic                  ex_valid_i,
    input  logic [REG_IDX_W-1:0]  ex_rd_i,
    input  logic [DATA_WIDTH-1:0] ex_result_i,
    input  logic                  wb_we_i,
    input  logic [REG_IDX_W-1:0]  wb_waddr_i,
    input  logic [DATA_WIDTH-1:0] wb_wdata_i,

    output logic                  dec_valid_o,
    output alu_op_e               dec_op_o,
    output logic [REG_IDX_W-1:0]  dec_rd_o,
    output logic [DATA_WIDTH-1:0] dec_a_o,
    output logic [DATA_WIDTH-1:0] dec_b_o,
    output logic                  dec_illegal_o
);

    logic                  instr_valid_q;
    logic [INSTR_W-1:0]    instr_q;
    opcode_e               opcode;
    logic [IMM_W-1:0]      imm;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic                  illegal;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= fetch_valid_i;
        end
        if (fetch_valid_i) begin
            instr_q <= fetch_instr_i;
        end
    end

    assign opcode       = opcode_e'(instr_q[OPCODE_LSB +: OPCODE_W]);
    assign imm          = instr_q[IMM_LSB +: IMM_W];
    assign rf_raddr_a_o = instr_q[RS1_LSB +: REG_IDX_W];
    assign rf_raddr_b_o = instr_q[RS2_LSB +: REG_IDX_W];

    // newest value wins: execute, then the pending write, then the file
    function automatic logic [DATA_WIDTH-1:0] read_operand(
        input logic [REG_IDX_W-1:0]  idx,
        input logic [DATA_WIDTH-1:0] rf_val
    );
        logic [DATA_WIDTH-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_valid_i && ex_rd_i == idx) begin
            val = ex_result_i;
        end else if (wb_we_i && wb_waddr_i == idx) begin
            val = wb_wdata_i;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        op_a     = read_operand(rf_raddr_a_o, rf_rdata_a_i);
        op_b     = read_operand(rf_raddr_b_o, rf_rdata_b_i);
        dec_op_o = ALU_ADD;
        dec_b_o  = op_b;
        illegal  = 1'b0;
        case (opcode)
            OP_ADD: dec_op_o = ALU_ADD;
            OP_SUB: dec_op_o = ALU_SUB;
            OP_AND: dec_op_o = ALU_AND;
            OP_OR:  dec_op_o = ALU_OR;
            OP_XOR: dec_op_o = ALU_XOR;
            OP_SLL: dec_op_o = ALU_SLL;
            OP_ADDI: begin
                dec_op_o = ALU_ADD;
                dec_b_o  = {{(DATA_WIDTH-IMM_W){imm[IMM_W-1]}}, imm};
            end
            OP_LUI: begin
                // upper half of the low word, zero below
                dec_op_o = ALU_PASS_B;
                dec_b_o  = DATA_WIDTH'({imm, {IMM_W{1'b0}}});
            end
            default: illegal = 1'b1;
        endcase
    end

    assign dec_valid_o   = instr_valid_q && !illegal;
    assign dec_illegal_o = instr_valid_q && illegal;
    assign dec_rd_o      = instr_q[RD_LSB +: REG_IDX_W];
    assign dec_a_o       = op_a;

endmodule

//--- hdl/instr_fetch.sv
// instruction fetch stage
// issues req/gnt requests from boot_addr_i upward, keeps up to
// MAX_OUTSTANDING in flight and latches each returned word
module instr_fetch import core_cfg_pkg::*; #(
    parameter int ADDR_WIDTH      = 32,
    parameter int MAX_OUTSTANDING = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  fetch_enable_i,
    input  logic [ADDR_WIDTH-1:0] boot_addr_i,

    output logic                  instr_req_o,
    output logic [ADDR_WIDTH-1:0] instr_addr_o,
    input  logic                  instr_gnt_i,
    input  logic                  instr_rvalid_i,
    input  logic [INSTR_W-1:0]    instr_rdata_i,

    output logic                  fetch_valid_o,
    output logic [INSTR_W-1:0]    fetch_instr_o
);

    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    logic                  started_q;
    logic [ADDR_WIDTH-1:0] pc_q;
    logic [CNT_W-1:0]      outstanding_q;
    logic                  req_accept;
    logic                  fetch_valid_q;
    logic [INSTR_W-1:0]    fetch_instr_q;

    // throttle once the response queue of the memory is full
    assign instr_req_o  = started_q && (outstanding_q < CNT_W'(MAX_OUTSTANDING));
    assign instr_addr_o = pc_q;
    assign req_accept   = instr_req_o && instr_gnt_i;

    // enable is sticky, fetching runs until the next reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            started_q <= 1'b0;
            pc_q      <= '0;
        end else begin
            if (fetch_enable_i) begin
                started_q <= 1'b1;
            end
            // pc tracks the boot address until the first request goes out
            if (!started_q) begin
                pc_q <= boot_addr_i;
            end else if (req_accept) begin
                pc_q <= pc_q + ADDR_WIDTH'(INSTR_BYTES);
            end
        end
    end

    // granted but not yet answered requests
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            outstanding_q <= '0;
        end else begin
            case ({req_accept, instr_rvalid_i})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    // fetch latch, one pulse per returned word
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= instr_rvalid_i;
        end
        if (instr_rvalid_i) begin
            fetch_instr_q <= instr_rdata_i;
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_instr_o = fetch_instr_q;

endmodule

//--- hdl/core_cfg_pkg.sv
// core configuration shared by the pipeline stages
// ALU operation encoding and instruction word sizes
package core_cfg_pkg;

    localparam int INSTR_W     = 32;
    localparam int INSTR_BYTES = INSTR_W / 8;

    localparam int ALU_OP_W = 3;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLL    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

endpackage

//--- hdl/isa_pkg.sv
// instruction set of the mini core
// fixed 32-bit format: opcode, rd, rs1, rs2 and a 16-bit immediate
package isa_pkg;

    // opcode field, top nibble of the word
    localparam int OPCODE_LSB = 28;
    localparam int OPCODE_W   = 4;

    // register index fields
    localparam int REG_IDX_W = 4;
    localparam int RD_LSB    = 24;
    localparam int RS1_LSB   = 20;
    localparam int RS2_LSB   = 16;

    // immediate sits in the low half of the word
    localparam int IMM_LSB = 0;
    localparam int IMM_W   = 16;

    // architectural registers, r0 hardwired to zero
    localparam int NUM_REGS = 16;

    // opcodes 8 to 15 are illegal
    typedef enum logic [OPCODE_W-1:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LUI  = 4'h7
    } opcode_e;

endpackage
